// ==== verilog/dvi_pkg.sv ====
// dvi subsystem shared definitions
// video timing, serial bus divider, transmitter register table and colour bars
package dvi_pkg;

	// horizontal timing in pixels, kept tiny for short simulations
	localparam integer H_ACTIVE = 16;
	localparam integer H_FRONT = 2;
	localparam integer H_SYNC = 3;
	localparam integer H_BACK = 3;
	localparam integer H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical timing in lines
	localparam integer V_ACTIVE = 8;
	localparam integer V_FRONT = 1;
	localparam integer V_SYNC = 2;
	localparam integer V_BACK = 1;
	localparam integer V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// position counter widths
	localparam integer X_BITS = 5;
	localparam integer Y_BITS = 4;

	// clocks per quarter of a serial bus bit period
	localparam integer IIC_DIV = 4;
	localparam integer IIC_DIV_BITS = $clog2(IIC_DIV);

	// 7-bit bus address of the transmitter
	localparam logic [6:0] IIC_DEV_ADDR = 7'h76;

	// register table written once after reset, in index order
	localparam integer REG_COUNT = 4;
	localparam integer REG_IDX_BITS = $clog2(REG_COUNT);

	localparam logic [7:0] REG_ADDR [0:REG_COUNT-1] = '{
		8'h49,	// power management
		8'h1C,	// clock mode
		8'h21,	// input data format
		8'h33	// pll charge pump
	};

	localparam logic [7:0] REG_DATA [0:REG_COUNT-1] = '{
		8'hC0,	// dvi encoder on
		8'h04,
		8'h09,
		8'h08
	};

	// controller states
	typedef enum logic [3:0] {
		IDLE,
		START,
		BIT_LOW,
		BIT_HIGH,
		ACK_LOW,
		ACK_HIGH,
		STOP,
		DONE,
		FAIL
	} iic_state_t;

	// one 24-bit colour per four-pixel bar, high 12 bits sent second
	localparam logic [23:0] BAR_COLOR [0:3] = '{
		24'hFFFFFF,
		24'hFFFF00,
		24'h00FFFF,
		24'hFF0000
	};

endpackage

// ==== verilog/video_timing_if.sv ====
// video timing bundle
// carries pixel phase, syncs, active flag and x position to the output stage
`timescale 1ns/1ns

interface video_timing_if;

	// 0 on the first clock of a pixel, 1 on the second
	logic pix_phase;

	// syncs are active low
	logic hs;
	logic vs;

	// high inside the visible area
	logic active;

	// pixel position within the line
	logic [dvi_pkg::X_BITS-1:0] x;

	// timing generator side
	modport source (
		output pix_phase,
		output hs,
		output vs,
		output active,
		output x
	);

	// output stage side
	modport sink (
		input pix_phase,
		input hs,
		input vs,
		input active,
		input x
	);

endinterface

// ==== verilog/dvi_timing_gen.sv ====
// video timing generator
// free-running pixel and line counters giving syncs, active area and x position
`timescale 1ns/1ns

module dvi_timing_gen (
	input logic clock,
	input logic reset,
	video_timing_if.source tim
);

	// counter end values and sync windows
	localparam logic [dvi_pkg::X_BITS-1:0] X_LAST = dvi_pkg::X_BITS'(dvi_pkg::H_TOTAL - 1);
	localparam logic [dvi_pkg::Y_BITS-1:0] Y_LAST = dvi_pkg::Y_BITS'(dvi_pkg::V_TOTAL - 1);
	localparam logic [dvi_pkg::X_BITS-1:0] HS_START =
		dvi_pkg::X_BITS'(dvi_pkg::H_ACTIVE + dvi_pkg::H_FRONT);
	localparam logic [dvi_pkg::X_BITS-1:0] HS_END =
		dvi_pkg::X_BITS'(dvi_pkg::H_ACTIVE + dvi_pkg::H_FRONT + dvi_pkg::H_SYNC);
	localparam logic [dvi_pkg::Y_BITS-1:0] VS_START =
		dvi_pkg::Y_BITS'(dvi_pkg::V_ACTIVE + dvi_pkg::V_FRONT);
	localparam logic [dvi_pkg::Y_BITS-1:0] VS_END =
		dvi_pkg::Y_BITS'(dvi_pkg::V_ACTIVE + dvi_pkg::V_FRONT + dvi_pkg::V_SYNC);

	logic pix_phase;
	logic [dvi_pkg::X_BITS-1:0] x_count;
	logic [dvi_pkg::Y_BITS-1:0] y_count;

	// two clocks per pixel, x moves on the second one
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pix_phase <= 1'b0;
			x_count <= '0;
			y_count <= '0;
		end else begin
			pix_phase <= ~pix_phase;
			if (pix_phase) begin
				if (x_count == X_LAST) begin
					x_count <= '0;
					// line advances on the x wrap
					if (y_count == Y_LAST) begin
						y_count <= '0;
					end else begin
						y_count <= y_count + 1'b1;
					end
				end else begin
					x_count <= x_count + 1'b1;
				end
			end
		end
	end

	// decoded from the counters
	assign tim.pix_phase = pix_phase;
	assign tim.x = x_count;

	// hs low for the sync pixels right after the front porch
	assign tim.hs = ~((x_count >= HS_START) && (x_count < HS_END));

	// vs low for the sync lines
	assign tim.vs = ~((y_count >= VS_START) && (y_count < VS_END));

	// visible area at the top left of the frame
	assign tim.active = (x_count < dvi_pkg::X_BITS'(dvi_pkg::H_ACTIVE)) &&
		(y_count < dvi_pkg::Y_BITS'(dvi_pkg::V_ACTIVE));

endmodule

// ==== verilog/dvi_iic_init.sv ====
// transmitter configuration controller
// two-wire bus master writing the register table once, then reporting done or error
`timescale 1ns/1ns

module dvi_iic_init (
	input logic clock,
	input logic reset,
	output logic scl,
	output logic sda_oe,
	input logic sda_in,
	output logic iic_done,
	output logic iic_error
);

	localparam logic [7:0] DEV_WRITE = {dvi_pkg::IIC_DEV_ADDR, 1'b0};
	localparam logic [dvi_pkg::REG_IDX_BITS-1:0] REG_LAST =
		dvi_pkg::REG_IDX_BITS'(dvi_pkg::REG_COUNT - 1);

	dvi_pkg::iic_state_t state;

	logic [dvi_pkg::IIC_DIV_BITS-1:0] div_count;
	logic tick;
	logic [1:0] quarter;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [dvi_pkg::REG_IDX_BITS-1:0] reg_idx;
	logic [7:0] shift;

	// quarter period divider
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			div_count <= '0;
		end else if (tick) begin
			div_count <= '0;
		end else begin
			div_count <= div_count + 1'b1;
		end
	end

	assign tick = (div_count == dvi_pkg::IIC_DIV_BITS'(dvi_pkg::IIC_DIV - 1));

	// all bus moves happen on quarter ticks
	// sda only changes while scl is low, except for start and stop
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= dvi_pkg::IDLE;
			quarter <= '0;
			bit_cnt <= '0;
			byte_cnt <= '0;
			reg_idx <= '0;
			shift <= '0;
			scl <= 1'b1;
			sda_oe <= 1'b0;
			iic_done <= 1'b0;
			iic_error <= 1'b0;
		end else if (tick) begin
			case (state)
				dvi_pkg::IDLE: begin
					// bus idles one quarter before the first start
					shift <= DEV_WRITE;
					quarter <= '0;
					state <= dvi_pkg::START;
				end
				dvi_pkg::START: begin
					if (quarter == 2'd0) begin
						// sda falls while scl high
						sda_oe <= 1'b1;
						quarter <= 2'd1;
					end else begin
						scl <= 1'b0;
						quarter <= '0;
						bit_cnt <= 3'd7;
						byte_cnt <= '0;
						state <= dvi_pkg::BIT_LOW;
					end
				end
				dvi_pkg::BIT_LOW: begin
					if (quarter == 2'd0) begin
						// msb first, pull low for a zero
						sda_oe <= ~shift[7];
						quarter <= 2'd1;
					end else begin
						scl <= 1'b1;
						quarter <= '0;
						state <= dvi_pkg::BIT_HIGH;
					end
				end
				dvi_pkg::BIT_HIGH: begin
					if (quarter == 2'd0) begin
						quarter <= 2'd1;
					end else begin
						scl <= 1'b0;
						quarter <= '0;
						shift <= {shift[6:0], 1'b0};
						if (bit_cnt == 3'd0) begin
							state <= dvi_pkg::ACK_LOW;
						end else begin
							bit_cnt <= bit_cnt - 3'd1;
							state <= dvi_pkg::BIT_LOW;
						end
					end
				end
				dvi_pkg::ACK_LOW: begin
					if (quarter == 2'd0) begin
						// hand the line to the transmitter
						sda_oe <= 1'b0;
						quarter <= 2'd1;
					end else begin
						scl <= 1'b1;
						quarter <= '0;
						state <= dvi_pkg::ACK_HIGH;
					end
				end
				dvi_pkg::ACK_HIGH: begin
					if (quarter == 2'd0) begin
						quarter <= 2'd1;
					end else if (sda_in) begin
						// no acknowledge, leave the bus released for good
						quarter <= '0;
						iic_error <= 1'b1;
						state <= dvi_pkg::FAIL;
					end else begin
						scl <= 1'b0;
						quarter <= '0;
						bit_cnt <= 3'd7;
						if (byte_cnt == 2'd2) begin
							state <= dvi_pkg::STOP;
						end else begin
							// register address follows the device byte, then the value
							if (byte_cnt == 2'd0) begin
								shift <= dvi_pkg::REG_ADDR[reg_idx];
							end else begin
								shift <= dvi_pkg::REG_DATA[reg_idx];
							end
							byte_cnt <= byte_cnt + 2'd1;
							state <= dvi_pkg::BIT_LOW;
						end
					end
				end
				dvi_pkg::STOP: begin
					case (quarter)
						2'd0: sda_oe <= 1'b1;
						2'd1: scl <= 1'b1;
						// sda rises while scl high
						2'd2: sda_oe <= 1'b0;
						default: begin
							if (reg_idx == REG_LAST) begin
								iic_done <= 1'b1;
								state <= dvi_pkg::DONE;
							end else begin
								reg_idx <= reg_idx + 1'b1;
								shift <= DEV_WRITE;
								state <= dvi_pkg::START;
							end
						end
					endcase
					quarter <= quarter + 2'd1;
				end
				dvi_pkg::DONE: begin
					quarter <= '0;
				end
				dvi_pkg::FAIL: begin
					quarter <= '0;
				end
				default: begin
					state <= dvi_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// ==== verilog/dvi_pixel_out.sv ====
// dvi output stage
// colour-bar pixels sent as two 12-bit half-words, held inactive until configured
`timescale 1ns/1ns

module dvi_pixel_out (
	input logic clock,
	input logic reset,
	video_timing_if.sink tim,
	input logic iic_done,
	output logic [11:0] dvi_d,
	output logic dvi_de,
	output logic dvi_h,
	output logic dvi_v,
	output logic xclk_p,
	output logic xclk_n
);

	logic [1:0] bar_index;
	logic [23:0] bar_color;
	logic [11:0] half_word;

	// four pixels per bar, only the active 16 pixels matter
	assign bar_index = tim.x[3:2];
	assign bar_color = dvi_pkg::BAR_COLOR[bar_index];

	// low half on phase 0, high half on phase 1, blank outside the active area
	always_comb begin
		if (!tim.active) begin
			half_word = '0;
		end else if (tim.pix_phase) begin
			half_word = bar_color[23:12];
		end else begin
			half_word = bar_color[11:0];
		end
	end

	// every output one clock behind the timing bundle
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			dvi_d <= '0;
			dvi_de <= 1'b0;
			dvi_h <= 1'b1;
			dvi_v <= 1'b1;
			xclk_p <= 1'b0;
			xclk_n <= 1'b1;
		end else if (iic_done) begin
			dvi_d <= half_word;
			dvi_de <= tim.active;
			dvi_h <= tim.hs;
			dvi_v <= tim.vs;
			// pixel clock pair follows the phase
			xclk_p <= tim.pix_phase;
			xclk_n <= ~tim.pix_phase;
		end else begin
			// transmitter not set up yet
			dvi_d <= '0;
			dvi_de <= 1'b0;
			dvi_h <= 1'b1;
			dvi_v <= 1'b1;
			xclk_p <= 1'b0;
			xclk_n <= 1'b1;
		end
	end

endmodule

// ==== verilog/dvi_top.sv ====
// dvi subsystem top level
// timing generator, transmitter configuration and output stage on one clock
`timescale 1ns/1ns

module dvi_top (
	input logic clock,
	input logic reset,
	input logic sda_in,
	output logic scl,
	output logic sda_oe,
	output logic dvi_reset_b,
	output logic dvi_h,
	output logic dvi_v,
	output logic dvi_de,
	output logic xclk_p,
	output logic xclk_n,
	output logic iic_done,
	output logic iic_error,
	output logic [11:0] dvi_d
);

	video_timing_if tim_bus ();

	// transmitter held in reset with the design
	assign dvi_reset_b = ~reset;

	dvi_timing_gen u_timing_gen (
		.clock (clock),
		.reset (reset),
		.tim (tim_bus.source)
	);

	dvi_iic_init u_iic_init (
		.clock (clock),
		.reset (reset),
		.scl (scl),
		.sda_oe (sda_oe),
		.sda_in (sda_in),
		.iic_done (iic_done),
		.iic_error (iic_error)
	);

	// video waits on iic_done
	dvi_pixel_out u_pixel_out (
		.clock (clock),
		.reset (reset),
		.tim (tim_bus.sink),
		.iic_done (iic_done),
		.dvi_d (dvi_d),
		.dvi_de (dvi_de),
		.dvi_h (dvi_h),
		.dvi_v (dvi_v),
		.xclk_p (xclk_p),
		.xclk_n (xclk_n)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// testbench clock and power-on reset
// 20 ns clock, reset held for 16 cycles and released just after an edge
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	localparam integer HALF_PERIOD = 10;
	localparam integer RESET_CYCLES = 16;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// release lands 2 ns after a rising edge like the rest of the stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 reset = 1'b0;
	end

endmodule

// ==== tb/dvi_props.sv ====
// dvi output stage properties
// gating before configuration, pixel clock pair and data enable outside hsync
`timescale 1ns/1ns

module dvi_props (
	input logic clock,
	input logic reset,
	input logic iic_done,
	input logic [11:0] dvi_d,
	input logic dvi_de,
	input logic dvi_h,
	input logic xclk_p,
	input logic xclk_n
);

	// read by the testbench at the end of the run
	int fail_count = 0;

	// outputs are registered, so a low done at an edge means the last edge was gated too
	gated_before_done: assert property (@(posedge clock) disable iff (reset)
		!iic_done |-> (dvi_de == 1'b0 && dvi_d == 12'h000))
	else begin
		fail_count++;
		$error("video output active before configuration finished");
	end

	pixel_clock_pair: assert property (@(posedge clock) disable iff (reset)
		xclk_n == ~xclk_p)
	else begin
		fail_count++;
		$error("xclk_n is not the inverse of xclk_p");
	end

	// sync sits in the blanking, never inside the active area
	de_outside_hsync: assert property (@(posedge clock) disable iff (reset)
		!dvi_h |-> !dvi_de)
	else begin
		fail_count++;
		$error("data enable high during horizontal sync");
	end

endmodule

bind dvi_pixel_out dvi_props u_props (
	.clock (clock),
	.reset (reset),
	.iic_done (iic_done),
	.dvi_d (dvi_d),
	.dvi_de (dvi_de),
	.dvi_h (dvi_h),
	.xclk_p (xclk_p),
	.xclk_n (xclk_n)
);

// ==== tb/dvi_tb.sv ====
// dvi subsystem testbench
// serial bus responder, register table check, output gating and colour-bar video
`timescale 1ns/1ns

module dvi_tb;

	localparam integer DONE_LIMIT = 6000;
	localparam integer VIDEO_LIMIT = 4000;
	localparam integer LINE_CLOCKS = 2 * dvi_pkg::H_TOTAL;
	localparam integer HS_FIRST = dvi_pkg::H_ACTIVE + dvi_pkg::H_FRONT;
	localparam integer VS_FIRST = dvi_pkg::V_ACTIVE + dvi_pkg::V_FRONT;

	logic clock;
	logic gen_reset;
	logic tb_reset = 1'b0;
	logic reset;
	logic sda_in;
	logic scl;
	logic sda_oe;
	logic dvi_reset_b;
	logic dvi_h;
	logic dvi_v;
	logic dvi_de;
	logic xclk_p;
	logic xclk_n;
	logic iic_done;
	logic iic_error;
	logic [11:0] dvi_d;

	// bus responder state
	logic ack_pull = 1'b0;
	logic in_frame = 1'b0;
	logic [7:0] shift_in = 8'h00;
	int bit_idx = 0;
	int byte_idx = 0;
	int byte_total = 0;
	int stop_count = 0;
	int refuse_at = -1;
	logic [7:0] byte_q [$];

	// pixel and line model, holds the timing state behind the current outputs
	logic m_phase;
	int m_x;
	int m_y;
	logic done_last;
	logic settle;
	logic video_on;
	logic count_en;
	logic [16:0] expected;
	int de_count;
	int h_low;
	int v_low;
	int frames;

	string test_name = "reset";
	int check_count = 0;
	int error_count = 0;

	// set when the test sequence cannot go on
	string abort_reason = "";

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.reset (gen_reset)
	);

	// power-on reset or a reset asked for by a test
	assign reset = gen_reset | tb_reset;

	// open drain line, low when either side pulls
	assign sda_in = ~(sda_oe | ack_pull);

	dvi_top u_dvi_top (
		.clock (clock),
		.reset (reset),
		.sda_in (sda_in),
		.scl (scl),
		.sda_oe (sda_oe),
		.dvi_reset_b (dvi_reset_b),
		.dvi_h (dvi_h),
		.dvi_v (dvi_v),
		.dvi_de (dvi_de),
		.xclk_p (xclk_p),
		.xclk_n (xclk_n),
		.iic_done (iic_done),
		.iic_error (iic_error),
		.dvi_d (dvi_d)
	);

	task automatic compare_value(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		check_count++;
		assert (act_val === exp_val) else begin
			error_count++;
			$display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
				test_name, what, exp_val, act_val);
		end
	endtask

	task automatic verify_reset_outputs(input logic released);
		compare_value("dvi_reset_b", released, dvi_reset_b);
		compare_value("scl", 1'b1, scl);
		compare_value("sda_oe", 1'b0, sda_oe);
		compare_value("iic_done", 1'b0, iic_done);
		compare_value("iic_error", 1'b0, iic_error);
		compare_value("dvi_de", 1'b0, dvi_de);
		compare_value("dvi_d", 12'h000, dvi_d);
		compare_value("dvi_h", 1'b1, dvi_h);
		compare_value("dvi_v", 1'b1, dvi_v);
		compare_value("xclk_p", 1'b0, xclk_p);
		compare_value("xclk_n", 1'b1, xclk_n);
	endtask

	// {dvi_d, dvi_de, dvi_h, dvi_v, xclk_p, xclk_n} for one timing state
	function automatic logic [16:0] expected_pixel(input logic phase, input int x,
		input int y, input logic done);
		logic active;
		logic hs;
		logic vs;
		logic [23:0] color;
		logic [11:0] half;
		active = (x < dvi_pkg::H_ACTIVE) && (y < dvi_pkg::V_ACTIVE);
		hs = !((x >= HS_FIRST) && (x < HS_FIRST + dvi_pkg::H_SYNC));
		vs = !((y >= VS_FIRST) && (y < VS_FIRST + dvi_pkg::V_SYNC));
		color = dvi_pkg::BAR_COLOR[(x / 4) % 4];
		// low half-word first, high half-word on the second clock
		half = !active ? 12'h000 : (phase ? color[23:12] : color[11:0]);
		if (!done) begin
			return {12'h000, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
		end
		return {half, active, hs, vs, phase, !phase};
	endfunction

	// responder clears with the design
	always @(posedge reset) begin
		in_frame = 1'b0;
		ack_pull = 1'b0;
		bit_idx = 0;
		byte_idx = 0;
	end

	// start and stop are sda edges while scl is high
	always @(negedge sda_in) begin
		if (scl === 1'b1) begin
			in_frame = 1'b1;
			bit_idx = 0;
			byte_idx = 0;
		end
	end

	always @(posedge sda_in) begin
		if (scl === 1'b1 && in_frame) begin
			in_frame = 1'b0;
			stop_count++;
		end
	end

	// eight data bits msb first, then the acknowledge clock
	always @(posedge scl) begin
		if (in_frame && !reset && byte_idx < 3) begin
			if (bit_idx < 8) begin
				shift_in = {shift_in[6:0], sda_in};
				bit_idx++;
			end else begin
				byte_q.push_back(shift_in);
				byte_total++;
				byte_idx++;
				bit_idx = 0;
			end
		end
	end

	// hold sda low over the acknowledge clock unless this byte is refused
	always @(negedge scl) begin
		#2;
		ack_pull = in_frame && (bit_idx == 8) && (byte_total != refuse_at);
	end

	// compare every clock, outputs are stable at the falling edge
	always @(negedge clock) begin
		if (reset) begin
			m_phase = 1'b0;
			m_x = 0;
			m_y = 0;
			done_last = 1'b0;
			settle = 1'b1;
			video_on = 1'b0;
			count_en = 1'b0;
			de_count = 0;
			h_low = 0;
			v_low = 0;
			frames = 0;
		end else if (settle) begin
			// released after the last edge, no output has moved yet
			settle = 1'b0;
			done_last = iic_done;
		end else begin
			expected = expected_pixel(m_phase, m_x, m_y, done_last);
			compare_value("dvi_d", expected[16:5], dvi_d);
			compare_value("{de,h,v,xclk_p,xclk_n}", expected[4:0],
				{dvi_de, dvi_h, dvi_v, xclk_p, xclk_n});
			// first xclk_p rise after done aligns the line counts
			if (!video_on && done_last && xclk_p === 1'b1) begin
				video_on = 1'b1;
			end
			if (video_on && !m_phase && m_x == 0 && m_y == 0) begin
				count_en = 1'b1;
			end
			if (count_en) begin
				de_count += dvi_de;
				h_low += !dvi_h;
				v_low += !dvi_v;
				if (m_phase && m_x == dvi_pkg::H_TOTAL - 1) begin
					compare_value("de clocks in line",
						(m_y < dvi_pkg::V_ACTIVE) ? 2 * dvi_pkg::H_ACTIVE : 0, de_count);
					compare_value("hsync clocks in line", 2 * dvi_pkg::H_SYNC, h_low);
					de_count = 0;
					h_low = 0;
					if (m_y == dvi_pkg::V_TOTAL - 1) begin
						compare_value("vsync clocks in frame",
							dvi_pkg::V_SYNC * LINE_CLOCKS, v_low);
						v_low = 0;
						frames++;
					end
				end
			end
			// advance to the state behind the next edge
			if (m_phase) begin
				if (m_x == dvi_pkg::H_TOTAL - 1) begin
					m_x = 0;
					m_y = (m_y == dvi_pkg::V_TOTAL - 1) ? 0 : m_y + 1;
				end else begin
					m_x++;
				end
			end
			m_phase = !m_phase;
			done_last = iic_done;
		end
	end

	// reset, register writes, video and refused acknowledge in order
	task automatic run_tests();
		int timer;
		@(negedge clock);
		verify_reset_outputs(1'b0);
		timer = 0;
		while (reset && timer < 40) begin
			@(negedge clock);
			timer++;
		end
		if (reset) begin
			abort_reason = "timeout while waiting for reset release";
			return;
		end
		verify_reset_outputs(1'b1);

		test_name = "register_writes";
		timer = 0;
		while (!iic_done && !iic_error && timer < DONE_LIMIT) begin
			@(negedge clock);
			timer++;
		end
		if (iic_error) begin
			abort_reason = "configuration stopped with iic_error";
			return;
		end
		if (!iic_done) begin
			abort_reason = "timeout while waiting for iic_done";
			return;
		end
		compare_value("transactions", dvi_pkg::REG_COUNT, stop_count);
		compare_value("bytes", 3 * dvi_pkg::REG_COUNT, byte_q.size());
		if (byte_q.size() == 3 * dvi_pkg::REG_COUNT) begin
			for (int i = 0; i < dvi_pkg::REG_COUNT; i++) begin
				compare_value("device byte", {dvi_pkg::IIC_DEV_ADDR, 1'b0}, byte_q[3 * i]);
				compare_value("register address", dvi_pkg::REG_ADDR[i], byte_q[3 * i + 1]);
				compare_value("register value", dvi_pkg::REG_DATA[i], byte_q[3 * i + 2]);
			end
		end

		test_name = "video";
		timer = 0;
		while (frames < 2 && timer < VIDEO_LIMIT) begin
			@(negedge clock);
			timer++;
		end
		if (frames < 2) begin
			abort_reason = "timeout while waiting for two video frames";
			return;
		end
		compare_value("iic_done held", 1'b1, iic_done);

		// fresh reset, the responder withholds one acknowledge
		test_name = "refused_ack";
		refuse_at = $urandom % (3 * dvi_pkg::REG_COUNT);
		byte_q.delete();
		byte_total = 0;
		stop_count = 0;
		@(posedge clock);
		#2 tb_reset = 1'b1;
		@(negedge clock);
		verify_reset_outputs(1'b0);
		repeat (15) @(posedge clock);
		#2 tb_reset = 1'b0;
		timer = 0;
		while (!iic_error && timer < DONE_LIMIT) begin
			@(negedge clock);
			timer++;
		end
		if (!iic_error) begin
			abort_reason = "timeout while waiting for iic_error";
			return;
		end
		compare_value("iic_done at error", 1'b0, iic_done);
		compare_value("bytes up to refusal", refuse_at + 1, byte_total);
		// one frame more, video stays gated
		repeat (LINE_CLOCKS * dvi_pkg::V_TOTAL) @(negedge clock);
		compare_value("iic_done after error", 1'b0, iic_done);
		compare_value("iic_error held", 1'b1, iic_error);
	endtask

	initial begin
		int prop_fails;
		void'($urandom(32'h78ccb0fd));
		run_tests();

		prop_fails = u_dvi_top.u_pixel_out.u_props.fail_count;
		if (abort_reason != "") begin
			$display("%s", abort_reason);
		end
		$display("checks %0d, errors %0d, property failures %0d, aborted %0d",
			check_count, error_count, prop_fails, abort_reason != "");
		if (abort_reason == "" && error_count == 0 && prop_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/dvi_pkg.sv
verilog/video_timing_if.sv
verilog/dvi_timing_gen.sv
verilog/dvi_iic_init.sv
verilog/dvi_pixel_out.sv
verilog/dvi_top.sv
tb/tb_clock_gen.sv
tb/dvi_props.sv
tb/dvi_tb.sv

// ==== Bender.yml ====
package:
  name: dvi_subsystem

sources:
  - verilog/dvi_pkg.sv
  - verilog/video_timing_if.sv
  - verilog/dvi_timing_gen.sv
  - verilog/dvi_iic_init.sv
  - verilog/dvi_pixel_out.sv
  - verilog/dvi_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/dvi_props.sv
      - tb/dvi_tb.sv
